/* Makefile */
SIM        := verilator
TOP        := link_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, the fail message means a failed run.
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+include
design/link_types_pkg.sv
design/link_fsm_pkg.sv
design/cdc_stream_if.sv
design/stream_cdc.sv
design/word_sender.sv
design/word_receiver.sv
design/cdc_word_link.sv
test/link_checker.sv
test/link_tb.sv

/* design/cdc_stream_if.sv */
interface cdc_stream_if #(
    parameter int WIDTH = 32
);
    logic [WIDTH-1:0] data;
    logic             valid;
    logic             last;
    logic             ok;     // word taken.

    // side that launches a word.
    modport producer (
        output data,
        output valid,
        output last,
        input  ok
    );

    // side that takes the word and answers with ok.
    modport consumer (
        input  data,
        input  valid,
        input  last,
        output ok
    );

endinterface

/* design/cdc_word_link.sv */
`include "link_defines.svh"

module cdc_word_link (
    input  logic                       clk_src,
    input  logic                       rst_src,
    input  logic                       clk_dst,
    input  logic                       rst_dst,
    input  link_types_pkg::data_word_t data_in,
    input  logic                       valid_in,
    output link_types_pkg::data_word_t data_out,
    output logic                       valid_out,
    output logic                       rdy,
    output logic                       done,
    output link_types_pkg::ack_word_t  ack_count
);
    // forward path, source to destination.
    cdc_stream_if #(.WIDTH(`LINK_DATA_W)) data_link ();
    cdc_stream_if #(.WIDTH(`LINK_DATA_W)) data_rx ();

    // return path, destination to source.
    cdc_stream_if #(.WIDTH(`LINK_ACK_W)) ack_link ();
    cdc_stream_if #(.WIDTH(`LINK_ACK_W)) ack_rx ();

    word_sender u_sender (
        .clk_src   (clk_src),
        .rst_src   (rst_src),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .rdy       (rdy),
        .done      (done),
        .ack_count (ack_count),
        .data_link (data_link.producer),
        .ack_rx    (ack_rx.consumer)
    );

    stream_cdc #(.WIDTH(`LINK_DATA_W)) u_data_cdc (
        .clk_src (clk_src),
        .rst_src (rst_src),
        .clk_dst (clk_dst),
        .rst_dst (rst_dst),
        .src     (data_link.consumer),
        .dst     (data_rx.producer)
    );

    word_receiver u_receiver (
        .clk_dst   (clk_dst),
        .rst_dst   (rst_dst),
        .data_out  (data_out),
        .valid_out (valid_out),
        .data_rx   (data_rx.consumer),
        .ack_link  (ack_link.producer)
    );

    // same crossing with the clocks swapped.
    stream_cdc #(.WIDTH(`LINK_ACK_W)) u_ack_cdc (
        .clk_src (clk_dst),
        .rst_src (rst_dst),
        .clk_dst (clk_src),
        .rst_dst (rst_src),
        .src     (ack_link.consumer),
        .dst     (ack_rx.producer)
    );

endmodule

/* design/link_fsm_pkg.sv */
package link_fsm_pkg;

    // source side states.
    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_DATA,
        SEND_WAIT_ACK
    } send_state_t;

    // destination side states.
    typedef enum logic {
        RECV_WAIT,
        RECV_ACK
    } recv_state_t;

endpackage

/* design/link_types_pkg.sv */
`include "link_defines.svh"

package link_types_pkg;

    // one word moved across the link.
    typedef logic [`LINK_DATA_W-1:0] data_word_t;

    // receive count returned with each acknowledge.
    typedef logic [`LINK_ACK_W-1:0] ack_word_t;

endpackage

/* design/stream_cdc.sv */
`include "link_defines.svh"

module stream_cdc #(
    parameter int WIDTH = 32
) (
    input  logic           clk_src,
    input  logic           rst_src,
    input  logic           clk_dst,
    input  logic           rst_dst,
    cdc_stream_if.consumer src,
    cdc_stream_if.producer dst
);
    localparam int SYNC = `LINK_SYNC_STAGES;

    logic [WIDTH-1:0] hold_data;
    logic             hold_last;
    logic             req_tgl;
    logic             busy;
    logic             launch;
    logic [SYNC-1:0]  ack_sync;
    logic             ack_seen;
    logic             src_ok;

    logic [SYNC-1:0]  req_sync;
    logic             req_seen;
    logic             req_edge;
    logic             dst_valid;
    logic             ack_tgl;

    // a new word is taken only once the last one has been answered.
    assign launch = src.valid && !busy;
    assign src.ok = src_ok;

    always_ff @(posedge clk_src) begin
        if (launch) begin
            hold_data <= src.data;
            hold_last <= src.last;
        end
    end

    always_ff @(posedge clk_src) begin
        if (rst_src) begin
            req_tgl  <= 1'b0;
            busy     <= 1'b0;
            ack_sync <= '0;
            ack_seen <= 1'b0;
            src_ok   <= 1'b0;
        end else begin
            ack_sync <= {ack_sync[SYNC-2:0], ack_tgl};
            ack_seen <= ack_sync[SYNC-1];
            src_ok   <= ack_sync[SYNC-1] ^ ack_seen;  // one pulse per returned toggle.
            if (launch) begin
                req_tgl <= ~req_tgl;
                busy    <= 1'b1;
            end else if (src_ok) begin
                busy <= 1'b0;
            end
        end
    end

    // request arrived on the destination side.
    assign req_edge  = req_sync[SYNC-1] ^ req_seen;
    assign dst.valid = dst_valid;

    always_ff @(posedge clk_dst) begin
        if (rst_dst) begin
            req_sync  <= '0;
            req_seen  <= 1'b0;
            dst_valid <= 1'b0;
            ack_tgl   <= 1'b0;
        end else begin
            req_sync  <= {req_sync[SYNC-2:0], req_tgl};
            req_seen  <= req_sync[SYNC-1];
            dst_valid <= req_edge;
            if (dst_valid && dst.ok) begin
                ack_tgl <= ~ack_tgl;  // hand the acknowledge back.
            end
        end
    end

    // hold register only changes after ok.
    always_ff @(posedge clk_dst) begin
        if (req_edge) begin
            dst.data <= hold_data;
            dst.last <= hold_last;
        end
    end

endmodule

/* design/word_receiver.sv */
module word_receiver (
    input  logic                       clk_dst,
    input  logic                       rst_dst,
    output link_types_pkg::data_word_t data_out,
    output logic                       valid_out,
    cdc_stream_if.consumer             data_rx,
    cdc_stream_if.producer             ack_link
);
    import link_fsm_pkg::*;
    import link_types_pkg::*;

    recv_state_t state;
    ack_word_t   rx_count;

    // a word is only taken while waiting for one.
    assign data_rx.ok = (state == RECV_WAIT);

    // count only moves in RECV_WAIT, so it is stable while the ack is out.
    assign ack_link.data = rx_count;

    always_ff @(posedge clk_dst) begin
        if (rst_dst) begin
            state          <= RECV_WAIT;
            rx_count       <= '0;
            data_out       <= '0;
            valid_out      <= 1'b0;
            ack_link.valid <= 1'b0;
            ack_link.last  <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            case (state)
                RECV_WAIT: begin
                    if (data_rx.valid && data_rx.last) begin
                        data_out       <= data_rx.data;
                        rx_count       <= rx_count + 1'b1;  // wraps at 256.
                        ack_link.valid <= 1'b1;
                        ack_link.last  <= 1'b1;
                        state          <= RECV_ACK;
                    end
                end
                RECV_ACK: begin
                    if (ack_link.ok) begin
                        ack_link.valid <= 1'b0;
                        ack_link.last  <= 1'b0;
                        valid_out      <= 1'b1;  // word is handed out now.
                        state          <= RECV_WAIT;
                    end
                end
                default: begin
                    state <= RECV_WAIT;
                end
            endcase
        end
    end

endmodule

/* design/word_sender.sv */
module word_sender (
    input  logic                      clk_src,
    input  logic                      rst_src,
    input  link_types_pkg::data_word_t data_in,
    input  logic                      valid_in,
    output logic                      rdy,
    output logic                      done,
    output link_types_pkg::ack_word_t  ack_count,
    cdc_stream_if.producer            data_link,
    cdc_stream_if.consumer            ack_rx
);
    import link_fsm_pkg::*;

    send_state_t state;
    logic        ack_here;
    logic        take_ack;

    assign rdy = (state == SEND_IDLE);

    // the acknowledge may land on the same cycle as the data ok.
    assign ack_here = ack_rx.valid && ack_rx.last;
    assign take_ack = (state == SEND_WAIT_ACK) || (state == SEND_DATA && data_link.ok);
    assign ack_rx.ok = take_ack;

    // payload register, loaded only while idle.
    always_ff @(posedge clk_src) begin
        if (rdy && valid_in) begin
            data_link.data <= data_in;
        end
    end

    always_ff @(posedge clk_src) begin
        if (rst_src) begin
            state           <= SEND_IDLE;
            data_link.valid <= 1'b0;
            data_link.last  <= 1'b0;
            done            <= 1'b0;
            ack_count       <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                SEND_IDLE: begin
                    if (valid_in) begin
                        data_link.valid <= 1'b1;
                        data_link.last  <= 1'b1;  // single word frames.
                        state           <= SEND_DATA;
                    end
                end
                SEND_DATA: begin
                    if (data_link.ok) begin
                        data_link.valid <= 1'b0;
                        data_link.last  <= 1'b0;
                        if (ack_here) begin
                            done      <= 1'b1;
                            ack_count <= ack_rx.data;
                            state     <= SEND_IDLE;
                        end else begin
                            state <= SEND_WAIT_ACK;
                        end
                    end
                end
                SEND_WAIT_ACK: begin
                    if (ack_here) begin
                        done      <= 1'b1;
                        ack_count <= ack_rx.data;  // receiver's count.
                        state     <= SEND_IDLE;
                    end
                end
                default: begin
                    state <= SEND_IDLE;
                end
            endcase
        end
    end

endmodule

/* include/link_defines.svh */
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// width of one transferred data word.
`define LINK_DATA_W 32

// width of the acknowledge payload.
// it carries the receiver's running word count.
`define LINK_ACK_W 8

// flops in each toggle synchronizer chain.
// keep at 2 or more.
`define LINK_SYNC_STAGES 2

`endif

/* test/link_checker.sv */
module link_checker (
    input logic                       clk_src,
    input logic                       rst_src,
    input logic                       rdy,
    input logic                       done,
    input logic                       link_valid,
    input link_types_pkg::data_word_t link_data
);
    timeunit 1ns;
    timeprecision 1ps;

    property done_one_cycle;
        @(posedge clk_src) disable iff (rst_src)
            done |=> !done;
    endproperty

    // done comes with rdy back, never while a word is being launched.
    property done_with_rdy;
        @(posedge clk_src) disable iff (rst_src)
            done |-> rdy;
    endproperty

    property data_held_with_valid;
        @(posedge clk_src) disable iff (rst_src)
            link_valid |=> (!link_valid || $stable(link_data));
    endproperty

    a_done_one_cycle: assert property (done_one_cycle)
        else $error("done stayed high for a second cycle");
    a_done_with_rdy: assert property (done_with_rdy)
        else $error("done high while the sender was not ready");
    a_data_held_with_valid: assert property (data_held_with_valid)
        else $error("crossing data changed while its valid was high");

endmodule

bind word_sender link_checker u_link_checker (
    .clk_src    (clk_src),
    .rst_src    (rst_src),
    .rdy        (rdy),
    .done       (done),
    .link_valid (data_link.valid),
    .link_data  (data_link.data)
);

/* test/link_tb.sv */
module link_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import link_types_pkg::*;

    localparam int SRC_HALF = 13;  // 26 ns source clock.
    localparam int DST_HALF = 20;  // 40 ns destination clock.
    localparam int N_RANDOM = 240;
    localparam int N_TOTAL = 280;  // past 256, so the receive count wraps.
    localparam int WATCH_WORDS = 300;
    localparam int WATCH_NS = WATCH_WORDS * 40 * 2 * SRC_HALF;
    localparam int QUIET_CYCLES = 64;
    localparam logic [31:0] LFSR_SEED = 32'h8b59_48e2;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic       clk_src = 1'b0;
    logic       clk_dst = 1'b0;
    logic       rst_src = 1'b1;
    logic       rst_dst = 1'b1;
    data_word_t data_in = '0;
    logic       valid_in = 1'b0;
    data_word_t data_out;
    logic       valid_out;
    logic       rdy;
    logic       done;
    ack_word_t  ack_count;

    logic [31:0] lfsr_state = LFSR_SEED;
    data_word_t  data_q[$];  // accepted words not yet seen on data_out.
    ack_word_t   ack_q[$];
    int          n_accepted = 0;
    int          n_done = 0;
    int          n_out = 0;

    cdc_word_link uut (
        .clk_src   (clk_src),
        .rst_src   (rst_src),
        .clk_dst   (clk_dst),
        .rst_dst   (rst_dst),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .data_out  (data_out),
        .valid_out (valid_out),
        .rdy       (rdy),
        .done      (done),
        .ack_count (ack_count)
    );

    initial begin
        forever #SRC_HALF clk_src = ~clk_src;
    end

    initial begin
        forever #DST_HALF clk_dst = ~clk_dst;
    end

    // each reset spans three cycles of its own clock.
    initial begin
        repeat (3) @(posedge clk_src);
        rst_src <= 1'b0;
    end

    initial begin
        repeat (3) @(posedge clk_dst);
        rst_dst <= 1'b0;
    end

    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_step()};
        end
        return val;
    endfunction

    // the receiver reports the running total of accepted words modulo 256.
    function automatic ack_word_t expect_word(input data_word_t word);
        data_q.push_back(word);
        n_accepted++;
        return ack_word_t'(n_accepted % 256);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic drive_words(input int target, input bit hold_valid);
        int gap;
        gap = 0;
        while (n_accepted < target) begin
            @(posedge clk_src);
            // rdy and valid_in still show what the sender sampled on this edge.
            if (rdy && valid_in) begin
                ack_q.push_back(expect_word(data_in));
                gap = int'(random_bits(3));
            end
            if (n_accepted >= target) begin
                valid_in <= 1'b0;
            end else if (hold_valid) begin
                valid_in <= 1'b1;
                data_in  <= random_bits(32);  // new value every cycle.
            end else if (gap > 0) begin
                gap--;
                valid_in <= 1'b0;
            end else if (rdy) begin
                valid_in <= 1'b1;
                data_in  <= random_bits(32);
            end else if (random_bits(1) == 32'd1) begin
                valid_in <= 1'b1;  // sender is busy and must drop this one.
                data_in  <= random_bits(32);
            end else begin
                valid_in <= 1'b0;
            end
        end
    endtask

    initial begin
        @(posedge clk_src);
        while (rst_src || rst_dst) begin
            @(posedge clk_src);
        end
        @(posedge clk_src);
        assert (rdy == 1'b1) else abort_run($sformatf("Mismatch rdy: got %h, expected 1", rdy));
        assert (done == 1'b0) else abort_run($sformatf("Mismatch done: got %h, expected 0", done));
        assert (valid_out == 1'b0)
            else abort_run($sformatf("Mismatch valid_out: got %h, expected 0", valid_out));
        assert (data_out == '0)
            else abort_run($sformatf("Mismatch data_out: got %h, expected 0", data_out));
        assert (ack_count == '0)
            else abort_run($sformatf("Mismatch ack_count: got %h, expected 0", ack_count));

        drive_words(N_RANDOM, 1'b0);
        drive_words(N_TOTAL, 1'b1);
        while (n_done < N_TOTAL) begin
            @(posedge clk_src);
        end
        repeat (QUIET_CYCLES) @(posedge clk_src);  // catch stray strobes.

        assert (n_out == n_done)
            else abort_run($sformatf("Mismatch valid_out count: got %h, done count %h",
                                     n_out, n_done));
        $display("TEST PASSED");
        $finish;
    end

    always @(posedge clk_dst) begin
        data_word_t exp_word;
        if (valid_out) begin
            assert (data_q.size() != 0)
                else abort_run("valid_out pulsed with no accepted word outstanding");
            exp_word = data_q.pop_front();
            n_out++;
            assert (data_out == exp_word)
                else abort_run($sformatf("Mismatch data_out: got %h, expected %h",
                                         data_out, exp_word));
        end
    end

    always @(posedge clk_src) begin
        ack_word_t exp_ack;
        if (done) begin
            assert (ack_q.size() != 0) else abort_run("done pulsed with no word in flight");
            exp_ack = ack_q.pop_front();
            n_done++;
            assert (ack_count == exp_ack)
                else abort_run($sformatf("Mismatch ack_count: got %h, expected %h",
                                         ack_count, exp_ack));
        end
    end

    initial begin
        #(WATCH_NS);
        abort_run("timeout: the link did not finish all words in the allowed time");
    end

endmodule
